// ==== design/preDecodePkg.sv ====
`default_nettype none

package preDecodePkg;

    localparam int InstWidth = 32;
    localparam int AddrWidth = 32;

    // one fetched instruction and one byte address
    typedef logic [InstWidth-1:0] instWordT;
    typedef logic [AddrWidth-1:0] instAddrT;

    // major opcode and register fields of an instruction word
    typedef logic [5:0] opcodeT;
    typedef logic [4:0] regIdxT;

    // encoding shared with the BTB type field
    typedef enum logic [2:0] {
        TypeNone   = 3'd0,
        TypeReturn = 3'd1,
        TypeCall   = 3'd2,
        TypeDirect = 3'd3,
        TypeBranch = 3'd4
    } branchTypeE;

    // indirect jump, return when rj=1 and rd=0, call when rd=1
    localparam opcodeT OpJumpReg = 6'b010011;

    // unconditional pc-relative jumps
    localparam opcodeT OpDirectLo = 6'b010100;
    localparam opcodeT OpDirectHi = 6'b010101;

    // conditional branches occupy this opcode range
    localparam opcodeT OpBranchLo = 6'b010110;
    localparam opcodeT OpBranchHi = 6'b011011;

    // link register and zero register numbers
    localparam regIdxT RegZero = 5'd0;
    localparam regIdxT RegLink = 5'd1;

endpackage

`default_nettype wire

// ==== design/slotClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module slotClassifier (
    input  wire preDecodePkg::instWordT  inst,
    input  wire preDecodePkg::instAddrT  pc,
    output preDecodePkg::branchTypeE     slotType,
    output preDecodePkg::instAddrT       directTarget,
    output preDecodePkg::instAddrT       branchTarget
);

    preDecodePkg::opcodeT opcode;
    preDecodePkg::regIdxT rd;
    preDecodePkg::regIdxT rj;

    assign opcode = inst[31:26];
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];

    always_comb begin
        slotType = preDecodePkg::TypeNone;
        if (opcode == preDecodePkg::OpJumpReg) begin
            if (rj == preDecodePkg::RegLink && rd == preDecodePkg::RegZero) begin
                slotType = preDecodePkg::TypeReturn;
            end else if (rd == preDecodePkg::RegLink) begin
                slotType = preDecodePkg::TypeCall;
            end
        end else if (opcode == preDecodePkg::OpDirectLo ||
                     opcode == preDecodePkg::OpDirectHi) begin
            slotType = preDecodePkg::TypeDirect;
        end else if (opcode >= preDecodePkg::OpBranchLo &&
                     opcode <= preDecodePkg::OpBranchHi) begin
            slotType = preDecodePkg::TypeBranch;
        end
    end

    // 26-bit offset, high part sits in bits 9:0
    assign directTarget = pc + {6'd0, inst[9:0], inst[25:10]};

    // branches only carry the 16-bit field
    assign branchTarget = pc + {16'd0, inst[25:10]};

endmodule

`default_nettype wire

// ==== design/btbChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module btbChecker #(
    parameter int SlotCount = 8
) (
    input  wire [SlotCount*3-1:0]                        slotTypes,
    input  wire [SlotCount*preDecodePkg::AddrWidth-1:0]  directTargets,
    input  wire [SlotCount*preDecodePkg::AddrWidth-1:0]  branchTargets,
    input  wire [SlotCount*preDecodePkg::AddrWidth-1:0]  fetchPc,
    input  wire [SlotCount-1:0]                          slotValid,
    input  wire                                          btbValid,
    input  wire [2:0]                                    btbType,
    input  wire preDecodePkg::instAddrT                  btbTarget,
    input  wire                                          rasValid,
    input  wire preDecodePkg::instAddrT                  rasTarget,
    input  wire                                          tageValid,
    input  wire                                          tageTaken,
    output logic [$clog2(SlotCount)-1:0]                 endSlot,
    output preDecodePkg::branchTypeE                     endType,
    output logic                                         typeFault,
    output logic                                         targetFault,
    output preDecodePkg::instAddrT                       fixTarget
);

    localparam int IdxWidth = $clog2(SlotCount);
    localparam preDecodePkg::instAddrT BlockBytes = preDecodePkg::instAddrT'(SlotCount * 4);

    preDecodePkg::branchTypeE typeArr   [SlotCount];
    preDecodePkg::instAddrT   pcArr     [SlotCount];
    preDecodePkg::instAddrT   directArr [SlotCount];
    preDecodePkg::instAddrT   branchArr [SlotCount];

    preDecodePkg::instAddrT   endPc;
    preDecodePkg::instAddrT   fallThrough;
    preDecodePkg::instAddrT   correctTarget;
    logic                     checkTarget;
    logic                     found;

    // slot 0 lives in the top slice
    for (genvar i = 0; i < SlotCount; i++) begin : gUnpack
        localparam int Pos = SlotCount - 1 - i;

        assign typeArr[i]   = preDecodePkg::branchTypeE'(slotTypes[Pos*3 +: 3]);
        assign pcArr[i]     = fetchPc[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth];
        assign directArr[i] =
            directTargets[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth];
        assign branchArr[i] =
            branchTargets[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth];
    end

    // first control-flow slot, or the last one before a hole
    always_comb begin
        found   = 1'b0;
        endSlot = IdxWidth'(SlotCount - 1);
        for (int i = 0; i < SlotCount - 1; i++) begin
            if (!found && (typeArr[i] != preDecodePkg::TypeNone ||
                           !slotValid[SlotCount-2-i])) begin
                found   = 1'b1;
                endSlot = IdxWidth'(i);
            end
        end
    end

    assign endType = typeArr[endSlot];
    assign endPc   = pcArr[endSlot];

    // next aligned fetch block
    assign fallThrough = (endPc & ~(BlockBytes - 1)) + BlockBytes;

    always_comb begin
        correctTarget = '0;
        checkTarget   = 1'b0;
        case (endType)
            preDecodePkg::TypeDirect: begin
                correctTarget = directArr[endSlot];
                checkTarget   = 1'b1;
            end
            preDecodePkg::TypeReturn: begin
                correctTarget = rasTarget;
                checkTarget   = rasValid;
            end
            preDecodePkg::TypeBranch: begin
                correctTarget = tageTaken ? branchArr[endSlot] : endPc + 32'd4;
                checkTarget   = tageValid;
            end
            preDecodePkg::TypeNone: begin
                correctTarget = fallThrough;
                checkTarget   = 1'b1;
            end
            // call target is unknown at predecode
            default: begin
                correctTarget = '0;
                checkTarget   = 1'b0;
            end
        endcase
    end

    assign typeFault   = btbValid && (btbType != endType);
    assign targetFault = btbValid && checkTarget && (correctTarget != btbTarget);
    assign fixTarget   = correctTarget;

endmodule

`default_nettype wire

// ==== design/decodeStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageReg #(
    parameter int SlotCount = 8
) (
    input  wire                                          Clk,
    input  wire                                          rstN,
    input  wire                                          stop,
    input  wire                                          flush,
    input  wire                                          fetchValid,
    input  wire [SlotCount*preDecodePkg::AddrWidth-1:0]  fetchPc,
    input  wire [SlotCount*preDecodePkg::InstWidth-1:0]  fetchData,
    input  wire [SlotCount*3-1:0]                        slotTypes,
    input  wire [$clog2(SlotCount)-1:0]                  endSlot,
    input  wire preDecodePkg::branchTypeE                endType,
    input  wire                                          typeFault,
    input  wire                                          targetFault,
    input  wire preDecodePkg::instAddrT                  fixTarget,
    input  wire preDecodePkg::instAddrT                  btbTarget,
    input  wire                                          tageValid,
    input  wire                                          tageTaken,
    output logic                                         redirectValid,
    output preDecodePkg::instAddrT                       redirectPc,
    output logic                                         btbFixValid,
    output logic                                         btbFixTypeValid,
    output preDecodePkg::branchTypeE                     btbFixType,
    output logic                                         btbFixTargetValid,
    output preDecodePkg::instAddrT                       btbFixTarget,
    output preDecodePkg::instAddrT                       btbFixPc,
    output logic [SlotCount-1:0]                         ibValid,
    output logic [SlotCount-1:0]                         ibTaken,
    output logic [SlotCount*preDecodePkg::AddrWidth-1:0] ibPc,
    output logic [SlotCount*preDecodePkg::AddrWidth-1:0] ibTarget,
    output logic [SlotCount*preDecodePkg::InstWidth-1:0] ibInst
);

    localparam int IdxWidth = $clog2(SlotCount);

    logic [SlotCount-1:0]                         validNext;
    logic [SlotCount-1:0]                         takenNext;
    logic [SlotCount*preDecodePkg::AddrWidth-1:0] targetNext;
    preDecodePkg::instAddrT                       slotTarget;

    // one target for every control-flow slot in the block
    assign slotTarget = targetFault ? fixTarget : btbTarget;

    for (genvar i = 0; i < SlotCount; i++) begin : gSlot
        localparam int Pos = SlotCount - 1 - i;
        logic isFlow;

        assign isFlow          = slotTypes[Pos*3 +: 3] != preDecodePkg::TypeNone;
        assign validNext[Pos]  = endSlot >= IdxWidth'(i);
        assign takenNext[Pos]  = isFlow ? (tageTaken & tageValid) : 1'b1;
        assign targetNext[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth] =
            isFlow ? slotTarget : '0;
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            redirectValid     <= 1'b0;
            redirectPc        <= '0;
            btbFixValid       <= 1'b0;
            btbFixTypeValid   <= 1'b0;
            btbFixType        <= preDecodePkg::TypeNone;
            btbFixTargetValid <= 1'b0;
            btbFixTarget      <= '0;
            btbFixPc          <= '0;
            ibValid           <= '0;
            ibTaken           <= '0;
            ibPc              <= '0;
            ibTarget          <= '0;
            ibInst            <= '0;
        end else if (!stop) begin
            if (flush) begin
                redirectValid     <= 1'b0;
                redirectPc        <= '0;
                btbFixValid       <= 1'b0;
                btbFixTypeValid   <= 1'b0;
                btbFixType        <= preDecodePkg::TypeNone;
                btbFixTargetValid <= 1'b0;
                btbFixTarget      <= '0;
                btbFixPc          <= '0;
                ibValid           <= '0;
                ibTaken           <= '0;
                ibPc              <= '0;
                ibTarget          <= '0;
                ibInst            <= '0;
            end else if (fetchValid) begin
                redirectValid     <= targetFault;
                redirectPc        <= fixTarget;
                btbFixValid       <= typeFault | targetFault;
                btbFixTypeValid   <= typeFault;
                btbFixType        <= endType;
                btbFixTargetValid <= targetFault;
                btbFixTarget      <= fixTarget;
                // BTB entries are indexed by the block start
                btbFixPc          <= fetchPc[(SlotCount-1)*preDecodePkg::AddrWidth +:
                                             preDecodePkg::AddrWidth];
                ibValid           <= validNext;
                ibTaken           <= takenNext;
                ibPc              <= fetchPc;
                ibTarget          <= targetNext;
                ibInst            <= fetchData;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/preDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module preDecode #(
    parameter int SlotCount = 8
) (
    input  wire                                          Clk,
    input  wire                                          rstN,
    input  wire                                          stop,
    input  wire                                          flush,
    input  wire                                          fetchValid,
    input  wire [SlotCount*preDecodePkg::AddrWidth-1:0]  fetchPc,
    input  wire [SlotCount*preDecodePkg::InstWidth-1:0]  fetchData,
    input  wire [SlotCount-1:0]                          slotValid,
    input  wire                                          btbValid,
    input  wire [2:0]                                    btbType,
    input  wire preDecodePkg::instAddrT                  btbTarget,
    input  wire                                          rasValid,
    input  wire preDecodePkg::instAddrT                  rasTarget,
    input  wire                                          tageValid,
    input  wire                                          tageTaken,
    output wire                                          redirectValid,
    output preDecodePkg::instAddrT                       redirectPc,
    output wire                                          btbFixValid,
    output wire                                          btbFixTypeValid,
    output preDecodePkg::branchTypeE                     btbFixType,
    output wire                                          btbFixTargetValid,
    output preDecodePkg::instAddrT                       btbFixTarget,
    output preDecodePkg::instAddrT                       btbFixPc,
    output wire [SlotCount-1:0]                          ibValid,
    output wire [SlotCount-1:0]                          ibTaken,
    output wire [SlotCount*preDecodePkg::AddrWidth-1:0]  ibPc,
    output wire [SlotCount*preDecodePkg::AddrWidth-1:0]  ibTarget,
    output wire [SlotCount*preDecodePkg::InstWidth-1:0]  ibInst
);

    wire [SlotCount*3-1:0]                        slotTypes;
    wire [SlotCount*preDecodePkg::AddrWidth-1:0]  directTargets;
    wire [SlotCount*preDecodePkg::AddrWidth-1:0]  branchTargets;
    wire [$clog2(SlotCount)-1:0]                  endSlot;
    wire preDecodePkg::branchTypeE                endType;
    wire                                          typeFault;
    wire                                          targetFault;
    wire preDecodePkg::instAddrT                  fixTarget;

    // one classifier per slot, slot 0 in the top slice
    for (genvar i = 0; i < SlotCount; i++) begin : gClassify
        localparam int Pos = SlotCount - 1 - i;

        slotClassifier i_slotClassifier (
            .inst         (fetchData[Pos*preDecodePkg::InstWidth +: preDecodePkg::InstWidth]),
            .pc           (fetchPc[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth]),
            .slotType     (slotTypes[Pos*3 +: 3]),
            .directTarget (directTargets[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth]),
            .branchTarget (branchTargets[Pos*preDecodePkg::AddrWidth +: preDecodePkg::AddrWidth])
        );
    end

    btbChecker #(
        .SlotCount (SlotCount)
    ) i_btbChecker (
        .slotTypes     (slotTypes),
        .directTargets (directTargets),
        .branchTargets (branchTargets),
        .fetchPc       (fetchPc),
        .slotValid     (slotValid),
        .btbValid      (btbValid),
        .btbType       (btbType),
        .btbTarget     (btbTarget),
        .rasValid      (rasValid),
        .rasTarget     (rasTarget),
        .tageValid     (tageValid),
        .tageTaken     (tageTaken),
        .endSlot       (endSlot),
        .endType       (endType),
        .typeFault     (typeFault),
        .targetFault   (targetFault),
        .fixTarget     (fixTarget)
    );

    decodeStageReg #(
        .SlotCount (SlotCount)
    ) i_decodeStageReg (
        .Clk               (Clk),
        .rstN              (rstN),
        .stop              (stop),
        .flush             (flush),
        .fetchValid        (fetchValid),
        .fetchPc           (fetchPc),
        .fetchData         (fetchData),
        .slotTypes         (slotTypes),
        .endSlot           (endSlot),
        .endType           (endType),
        .typeFault         (typeFault),
        .targetFault       (targetFault),
        .fixTarget         (fixTarget),
        .btbTarget         (btbTarget),
        .tageValid         (tageValid),
        .tageTaken         (tageTaken),
        .redirectValid     (redirectValid),
        .redirectPc        (redirectPc),
        .btbFixValid       (btbFixValid),
        .btbFixTypeValid   (btbFixTypeValid),
        .btbFixType        (btbFixType),
        .btbFixTargetValid (btbFixTargetValid),
        .btbFixTarget      (btbFixTarget),
        .btbFixPc          (btbFixPc),
        .ibValid           (ibValid),
        .ibTaken           (ibTaken),
        .ibPc              (ibPc),
        .ibTarget          (ibTarget),
        .ibInst            (ibInst)
    );

endmodule

`default_nettype wire

// ==== verif/preDecodeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module preDecodeTb;

    localparam int SlotCount = 8;
    // ns allowed per clock cycle of a wait
    localparam int Timeout   = 20;
    localparam int SnapWidth = 4 + 3 + 3*32 + 2*SlotCount + 3*SlotCount*32;

    logic                    Clk;
    logic                    rstN;
    logic                    stop;
    logic                    flush;
    logic                    fetchValid;
    logic [SlotCount*32-1:0] fetchPc;
    logic [SlotCount*32-1:0] fetchData;
    logic [SlotCount-1:0]    slotValid;
    logic                    btbValid;
    logic [2:0]              btbType;
    logic [31:0]             btbTarget;
    logic                    rasValid;
    logic [31:0]             rasTarget;
    logic                    tageValid;
    logic                    tageTaken;

    wire                    redirectValid;
    wire [31:0]             redirectPc;
    wire                    btbFixValid;
    wire                    btbFixTypeValid;
    wire [2:0]              btbFixType;
    wire                    btbFixTargetValid;
    wire [31:0]             btbFixTarget;
    wire [31:0]             btbFixPc;
    wire [SlotCount-1:0]    ibValid;
    wire [SlotCount-1:0]    ibTaken;
    wire [SlotCount*32-1:0] ibPc;
    wire [SlotCount*32-1:0] ibTarget;
    wire [SlotCount*32-1:0] ibInst;

    logic [31:0] pcs   [SlotCount];
    logic [31:0] insts [SlotCount];
    logic [31:0] lcgState;
    int          cycleCount;
    int          errors;
    int          testErrors;
    int          testsRun;

    // expected results of the current block
    int          expEnd;
    logic [2:0]  expType;
    logic [31:0] expFix;
    logic        expTypeFault;
    logic        expTargetFault;

    preDecode #(
        .SlotCount (SlotCount)
    ) i_preDecode (
        .Clk (Clk), .rstN (rstN), .stop (stop), .flush (flush),
        .fetchValid (fetchValid), .fetchPc (fetchPc), .fetchData (fetchData),
        .slotValid (slotValid), .btbValid (btbValid), .btbType (btbType),
        .btbTarget (btbTarget), .rasValid (rasValid), .rasTarget (rasTarget),
        .tageValid (tageValid), .tageTaken (tageTaken),
        .redirectValid (redirectValid), .redirectPc (redirectPc),
        .btbFixValid (btbFixValid), .btbFixTypeValid (btbFixTypeValid),
        .btbFixType (btbFixType), .btbFixTargetValid (btbFixTargetValid),
        .btbFixTarget (btbFixTarget), .btbFixPc (btbFixPc),
        .ibValid (ibValid), .ibTaken (ibTaken), .ibPc (ibPc),
        .ibTarget (ibTarget), .ibInst (ibInst)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [2:0] refType(input logic [31:0] inst);
        logic [5:0] op;
        op = inst[31:26];
        if (op == 6'b010011) begin
            if (inst[9:5] == 5'd1 && inst[4:0] == 5'd0) return 3'd1;
            if (inst[4:0] == 5'd1) return 3'd2;
            return 3'd0;
        end
        if (op == 6'b010100 || op == 6'b010101) return 3'd3;
        if (op >= 6'b010110 && op <= 6'b011011) return 3'd4;
        return 3'd0;
    endfunction

    // every DUT output in one vector
    function automatic logic [SnapWidth-1:0] outputSnapshot();
        return {redirectValid, redirectPc, btbFixValid, btbFixTypeValid, btbFixType,
                btbFixTargetValid, btbFixTarget, btbFixPc, ibValid, ibTaken,
                ibPc, ibTarget, ibInst};
    endfunction

    // expected end slot, type, target and faults from the current inputs
    task automatic computeExpected();
        logic check;
        expEnd = SlotCount - 1;
        for (int i = SlotCount - 2; i >= 0; i--) begin
            if (refType(insts[i]) != 3'd0 || !slotValid[SlotCount-2-i]) expEnd = i;
        end
        expType = refType(insts[expEnd]);
        check   = 1'b1;
        case (expType)
            3'd3: expFix = pcs[expEnd] + {6'd0, insts[expEnd][9:0], insts[expEnd][25:10]};
            3'd1: begin
                expFix = rasTarget;
                check  = rasValid;
            end
            3'd4: begin
                expFix = tageTaken ? pcs[expEnd] + {16'd0, insts[expEnd][25:10]}
                                   : pcs[expEnd] + 32'd4;
                check  = tageValid;
            end
            3'd0: expFix = (pcs[expEnd] & ~32'd31) + 32'd32;
            default: begin
                expFix = 32'd0;
                check  = 1'b0;
            end
        endcase
        expTypeFault   = btbValid && (btbType != expType);
        expTargetFault = btbValid && check && (expFix != btbTarget);
    endtask

    task automatic checkVal(input string name, input string field,
                            input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, field, exp, act);
            testErrors++;
        end
    endtask

    // step in 1 ns until n more clock edges have passed
    task automatic waitCycles(input int n);
        int target;
        int guard;
        target = cycleCount + n;
        guard  = 0;
        while (cycleCount < target && guard <= n * Timeout) begin
            #1;
            guard++;
        end
        if (cycleCount < target) begin
            $display("Timeout: clock stopped advancing");
            $display("Simulation finished: FAIL");
            $finish;
        end
    endtask

    // block with pc base, filler words and slot types left to the caller
    task automatic newBlock();
        logic [31:0] base;
        logic [31:0] rnd;
        base = nextRand() & ~32'd31;
        for (int i = 0; i < SlotCount; i++) begin
            rnd      = nextRand();
            pcs[i]   = base + 32'(4 * i);
            insts[i] = {6'b000000, rnd[25:0]};
        end
    endtask

    task automatic driveBlock();
        for (int i = 0; i < SlotCount; i++) begin
            fetchPc[(SlotCount-1-i)*32 +: 32]   = pcs[i];
            fetchData[(SlotCount-1-i)*32 +: 32] = insts[i];
        end
        fetchValid = 1'b1;
        computeExpected();
        waitCycles(1);
        fetchValid = 1'b0;
    endtask

    task automatic checkOutputs(input string name);
        logic [31:0] tgt;
        logic        flow;
        checkVal(name, "redirectValid", 32'(expTargetFault), 32'(redirectValid));
        checkVal(name, "redirectPc", expFix, redirectPc);
        checkVal(name, "btbFixValid", 32'(expTypeFault | expTargetFault), 32'(btbFixValid));
        checkVal(name, "btbFixTypeValid", 32'(expTypeFault), 32'(btbFixTypeValid));
        checkVal(name, "btbFixType", 32'(expType), 32'(btbFixType));
        checkVal(name, "btbFixTargetValid", 32'(expTargetFault), 32'(btbFixTargetValid));
        checkVal(name, "btbFixTarget", expFix, btbFixTarget);
        checkVal(name, "btbFixPc", pcs[0], btbFixPc);
        tgt = expTargetFault ? expFix : btbTarget;
        for (int i = 0; i < SlotCount; i++) begin
            flow = refType(insts[i]) != 3'd0;
            checkVal(name, $sformatf("ibValid[%0d]", i), 32'(i <= expEnd),
                     32'(ibValid[SlotCount-1-i]));
            checkVal(name, $sformatf("ibTaken[%0d]", i), 32'(flow ? tageTaken & tageValid : 1'b1),
                     32'(ibTaken[SlotCount-1-i]));
            checkVal(name, $sformatf("ibTarget[%0d]", i), flow ? tgt : 32'd0,
                     ibTarget[(SlotCount-1-i)*32 +: 32]);
            checkVal(name, $sformatf("ibPc[%0d]", i), pcs[i], ibPc[(SlotCount-1-i)*32 +: 32]);
            checkVal(name, $sformatf("ibInst[%0d]", i), insts[i], ibInst[(SlotCount-1-i)*32 +: 32]);
        end
    endtask

    task automatic endTest(input string name);
        testsRun++;
        errors += testErrors;
        if (testErrors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, testErrors);
        testErrors = 0;
    endtask

    task automatic testDirect();
        newBlock();
        insts[3]  = {6'b010100, 16'h0040, 10'd0};
        btbValid  = 1'b1;
        btbType   = 3'd3;
        btbTarget = pcs[3] + 32'h1234;
        driveBlock();
        checkOutputs("direct");
        endTest("direct");
    endtask

    task automatic testBranch(input logic taken);
        newBlock();
        insts[1]  = {6'b010110, 16'h0020, 10'd0};
        btbType   = 3'd4;
        btbTarget = pcs[1] + 32'h20;
        tageValid = 1'b1;
        tageTaken = taken;
        driveBlock();
        checkOutputs(taken ? "branchTaken" : "branchNotTaken");
        endTest(taken ? "branchTaken" : "branchNotTaken");
    endtask

    task automatic testReturnCall();
        newBlock();
        insts[2]  = {6'b010011, 16'd0, 5'd1, 5'd0};
        btbType   = 3'd1;
        btbTarget = 32'h0000_2000;
        rasValid  = 1'b1;
        rasTarget = 32'h8000_1000;
        driveBlock();
        checkOutputs("return");
        newBlock();
        insts[0]  = {6'b010011, 16'd0, 5'd0, 5'd1};
        btbType   = 3'd3;
        driveBlock();
        checkOutputs("call");
        endTest("returnCall");
    endtask

    task automatic testFallThrough();
        newBlock();
        slotValid = 8'b1111_1100;
        btbType   = 3'd0;
        btbTarget = pcs[0] + 32'h100;
        driveBlock();
        checkOutputs("fallThrough");
        slotValid = '1;
        endTest("fallThrough");
    endtask

    task automatic testStopFlush();
        logic [SnapWidth-1:0] held;
        held = outputSnapshot();
        stop = 1'b1;
        newBlock();
        insts[4] = {6'b010100, 16'h0100, 10'd0};
        driveBlock();
        if (outputSnapshot() !== held) begin
            $display("Mismatch stop outputs: expected %h, actual %h", held, outputSnapshot());
            testErrors++;
        end
        stop  = 1'b0;
        flush = 1'b1;
        waitCycles(1);
        flush = 1'b0;
        checkVal("flush", "redirectValid", 32'd0, 32'(redirectValid));
        checkVal("flush", "btbFixValid", 32'd0, 32'(btbFixValid));
        checkVal("flush", "ibValid", 32'd0, 32'(ibValid));
        endTest("stopFlush");
    endtask

    initial begin
        lcgState   = 32'ha8a3;
        errors     = 0;
        testErrors = 0;
        testsRun   = 0;
        rstN       = 1'b0;
        stop       = 1'b0;
        flush      = 1'b0;
        fetchValid = 1'b0;
        fetchPc    = '0;
        fetchData  = '0;
        slotValid  = '1;
        btbValid   = 1'b1;
        btbType    = 3'd0;
        btbTarget  = '0;
        rasValid   = 1'b0;
        rasTarget  = '0;
        tageValid  = 1'b0;
        tageTaken  = 1'b0;
        waitCycles(3);
        rstN = 1'b1;
        waitCycles(1);

        testDirect();
        testBranch(1'b1);
        testBranch(1'b0);
        tageValid = 1'b0;
        tageTaken = 1'b0;
        testReturnCall();
        rasValid = 1'b0;
        testFallThrough();
        testStopFlush();

        $display("tests run %0d, errors %0d", testsRun, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/preDecodePkg.sv
design/slotClassifier.sv
design/btbChecker.sv
design/decodeStageReg.sv
design/preDecode.sv
verif/preDecodeTb.sv

// ==== Makefile ====
TOP = preDecodeTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
